//--- hdl/norm_check_pkg.sv
// ML-DSA constants, coefficient and memory word types, norm-check mode enum
package norm_check_pkg;

    // Prime modulus q of ML-DSA
    localparam int mldsa_q = 8380417;

    // Each memory slot is 24 bits wide, the coefficient only needs 23
    localparam int reg_size = 24;
    localparam int coeff_width = 23;

    typedef logic [coeff_width-1:0] coeff_t;

    // Four coefficients are packed per memory word, lane 0 in the low slot
    localparam int lanes = 4;

    typedef logic [lanes*reg_size-1:0] mem_word_t;

    localparam int mem_addr_width = 10;

    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // ML-DSA-87 parameter set
    localparam int gamma1 = 524288;
    localparam int gamma2 = 261888;
    localparam int beta = 120;

    // A coefficient passes when its centred magnitude is strictly below these
    localparam coeff_t z_bound = coeff_t'(gamma1 - beta);
    localparam coeff_t r0_bound = coeff_t'(gamma2 - beta);
    localparam coeff_t ct0_bound = coeff_t'(gamma2);

    // z has l polynomials, r0 and ct0 have k
    localparam int poly_count_l = 7;
    localparam int poly_count_k = 8;

    // Selects which vector is checked and against which bound
    typedef enum logic [1:0] {
        chk_z,
        chk_r0,
        chk_ct0
    } chk_norm_mode_t;

endpackage

//--- hdl/coeff_mem.sv
// Coefficient word memory with one write port and one registered read port
`timescale 1ns/100ps

module coeff_mem (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      wr_en,
    input  norm_check_pkg::mem_addr_t wr_addr,
    input  norm_check_pkg::mem_word_t wr_data,
    input  logic                      rd_en,
    input  norm_check_pkg::mem_addr_t rd_addr,
    output norm_check_pkg::mem_word_t rd_data,
    output logic                      rd_data_valid
);
    import norm_check_pkg::*;

    localparam int depth = 2 ** mem_addr_width;

    // Storage array, one entry per four-coefficient word
    mem_word_t mem [depth];

    // Write and read share one process, so a read of the address being
    // written in the same cycle still returns the previous contents
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Read data is valid in the cycle after the request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

endmodule

//--- hdl/norm_check_unit.sv
// Single-coefficient norm check: centring modulo q and bound compare by mode
`timescale 1ns/100ps

module norm_check_unit (
    input  norm_check_pkg::chk_norm_mode_t mode,
    input  norm_check_pkg::coeff_t         coeff,
    output logic                           invalid
);
    import norm_check_pkg::*;

    // Largest value that still counts as non-negative after centring
    localparam coeff_t half_q = coeff_t'((mldsa_q - 1) / 2);
    localparam coeff_t q_val = coeff_t'(mldsa_q);

    // Centred magnitude of the coefficient
    coeff_t magnitude;
    // Bound of the selected check
    coeff_t bound;

    // Values above (q-1)/2 stand for negative numbers, so their
    // magnitude is the distance to q
    always_comb begin
        if (coeff <= half_q) begin
            magnitude = coeff;
        end else begin
            magnitude = q_val - coeff;
        end
    end

    // Bound selection by check mode
    always_comb begin
        case (mode)
            chk_z: begin
                bound = z_bound;
            end
            chk_r0: begin
                bound = r0_bound;
            end
            chk_ct0: begin
                bound = ct0_bound;
            end
            default: begin
                // Unused encoding, a zero bound fails every coefficient
                bound = '0;
            end
        endcase
    end

    // The norm must stay strictly below the bound
    // Gating with read-valid happens in the accumulator
    assign invalid = (magnitude >= bound);

endmodule

//--- hdl/norm_check_ctrl.sv
// Norm-check controller FSM: start handshake, rotated read addresses, clear and done
`timescale 1ns/100ps

module norm_check_ctrl #(
    parameter int mldsa_n = 256
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize,
    input  logic                           start_valid,
    output logic                           start_ready,
    input  norm_check_pkg::chk_norm_mode_t mode_in,
    output norm_check_pkg::chk_norm_mode_t mode,
    input  norm_check_pkg::mem_addr_t      mem_base_addr,
    input  logic [5:0]                     randomness,
    output logic                           rd_en,
    output norm_check_pkg::mem_addr_t      rd_addr,
    output logic                           run_clear,
    output logic                           reads_done,
    input  logic                           result_valid
);
    import norm_check_pkg::*;

    // Memory words per polynomial
    localparam int words = mldsa_n / lanes;
    localparam int word_width = (words > 1) ? $clog2(words) : 1;

    typedef logic [word_width-1:0] word_idx_t;
    typedef logic [3:0] poly_idx_t;

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_read,
        st_drain,
        st_release
    } state_t;

    state_t state;
    // Address of word 0 of the current polynomial
    mem_addr_t poly_addr;
    poly_idx_t poly_cnt;
    word_idx_t word_cnt;
    // Rotation of the word order, fixed for the whole run
    word_idx_t start_off;
    // High in the cycle after the last request, while its data returns
    logic last_req;

    poly_idx_t poly_last;
    logic last_word;
    logic last_addr;
    logic [word_width:0] off_sum;
    word_idx_t offset;

    // z is a vector of l polynomials, r0 and ct0 of k
    assign poly_last = (mode == chk_z) ? poly_idx_t'(poly_count_l - 1) :
                                         poly_idx_t'(poly_count_k - 1);

    assign last_word = (word_cnt == word_idx_t'(words - 1));
    assign last_addr = last_word && (poly_cnt == poly_last);

    // Word offset inside the polynomial, wrapping past the last word
    assign off_sum = start_off + word_cnt;
    assign offset = (off_sum >= words) ? word_idx_t'(off_sum - words) : word_idx_t'(off_sum);

    assign rd_addr = poly_addr + mem_addr_t'(offset);

    // Reads overlap the clear cycle, so the first request goes out right after accept
    assign rd_en = (state == st_clear) || (state == st_read);
    assign run_clear = (state == st_clear);
    assign start_ready = (state == st_idle);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            mode <= chk_z;
            poly_addr <= '0;
            poly_cnt <= '0;
            word_cnt <= '0;
            start_off <= '0;
            last_req <= 1'b0;
            reads_done <= 1'b0;
        end else if (zeroize) begin
            // Abandon the run, no result follows
            state <= st_idle;
            mode <= chk_z;
            poly_addr <= '0;
            poly_cnt <= '0;
            word_cnt <= '0;
            start_off <= '0;
            last_req <= 1'b0;
            reads_done <= 1'b0;
        end else begin
            last_req <= 1'b0;
            // Done once the last word has been folded into the flag
            reads_done <= last_req;
            case (state)
                st_idle: begin
                    if (start_valid && start_ready) begin
                        state <= st_clear;
                        mode <= mode_in;
                        poly_addr <= mem_base_addr;
                        poly_cnt <= '0;
                        word_cnt <= '0;
                        start_off <= word_idx_t'(randomness % words);
                    end
                end
                st_clear, st_read: begin
                    state <= st_read;
                    if (last_word) begin
                        word_cnt <= '0;
                        poly_cnt <= poly_cnt + 1'b1;
                        poly_addr <= poly_addr + mem_addr_t'(words);
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (last_addr) begin
                        state <= st_drain;
                        last_req <= 1'b1;
                    end
                end
                st_drain: begin
                    // Result pulse comes the cycle after reads_done
                    if (reads_done) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    // One cycle with ready low so the flag can be captured
                    if (result_valid) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- hdl/norm_check_accum.sv
// Norm-check result accumulator: sticky OR of lane flags, result pulse and held flag
`timescale 1ns/100ps

module norm_check_accum (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic                             run_clear,
    input  logic                             rd_data_valid,
    input  logic [norm_check_pkg::lanes-1:0] lane_invalid,
    input  logic                             reads_done,
    output logic                             result_valid,
    output logic                             result_invalid
);

    // Sticky flag over the whole vector
    logic invalid_q;

    // Lane flags only count on a returned word
    // run_clear and the first valid word never share a cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid_q <= 1'b0;
        end else if (zeroize) begin
            invalid_q <= 1'b0;
        end else if (run_clear) begin
            invalid_q <= 1'b0;
        end else if (rd_data_valid) begin
            invalid_q <= invalid_q | (|lane_invalid);
        end
    end

    // Result pulse is a registered copy of reads_done
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid <= 1'b0;
        end else if (zeroize) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= reads_done;
        end
    end

    // The flag stays put until the next run clears it
    assign result_invalid = invalid_q;

endmodule

//--- hdl/norm_check_top.sv
// Norm-check subsystem top: controller, coefficient memory, four check lanes, accumulator
`timescale 1ns/100ps

module norm_check_top #(
    parameter int mldsa_n = 256
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize,
    input  logic                           mem_wr_en,
    input  norm_check_pkg::mem_addr_t      mem_wr_addr,
    input  norm_check_pkg::mem_word_t      mem_wr_data,
    input  logic                           start_valid,
    output logic                           start_ready,
    input  norm_check_pkg::chk_norm_mode_t mode,
    input  norm_check_pkg::mem_addr_t      mem_base_addr,
    input  logic [5:0]                     randomness,
    output logic                           result_valid,
    output logic                           result_invalid
);
    import norm_check_pkg::*;

    logic rd_en;
    mem_addr_t rd_addr;
    mem_word_t rd_data;
    logic rd_data_valid;
    // Mode captured at accept, shared by all lanes
    chk_norm_mode_t chk_mode;
    logic [lanes-1:0] lane_invalid;
    logic run_clear;
    logic reads_done;

    norm_check_ctrl #(
        .mldsa_n(mldsa_n)
    ) norm_check_ctrl_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .start_valid(start_valid),
        .start_ready(start_ready),
        .mode_in(mode),
        .mode(chk_mode),
        .mem_base_addr(mem_base_addr),
        .randomness(randomness),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .run_clear(run_clear),
        .reads_done(reads_done),
        .result_valid(result_valid)
    );

    coeff_mem coeff_mem_i (
        .clk(clk),
        .reset_n(reset_n),
        .wr_en(mem_wr_en),
        .wr_addr(mem_wr_addr),
        .wr_data(mem_wr_data),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .rd_data_valid(rd_data_valid)
    );

    // One lane per slot, the top bit of each 24-bit slot is unused
    for (genvar i = 0; i < lanes; i++) begin : gen_lane
        norm_check_unit norm_check_unit_i (
            .mode(chk_mode),
            .coeff(rd_data[i*reg_size +: $bits(coeff_t)]),
            .invalid(lane_invalid[i])
        );
    end

    norm_check_accum norm_check_accum_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .run_clear(run_clear),
        .rd_data_valid(rd_data_valid),
        .lane_invalid(lane_invalid),
        .reads_done(reads_done),
        .result_valid(result_valid),
        .result_invalid(result_invalid)
    );

endmodule

//--- test/norm_check_tb.sv
// Norm-check testbench: clock, reset, stimulus reader, memory loader, start driver, checks
`timescale 1ns/100ps

module norm_check_tb;
    import norm_check_pkg::*;

    localparam int mldsa_n = 16;
    localparam int words_per_poly = mldsa_n / lanes;
    // Words written per case, enough for the longest vector
    localparam int load_words = words_per_poly * poly_count_k;
    localparam int wait_margin = 10;
    localparam int ready_limit = 200;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic mem_wr_en;
    mem_addr_t mem_wr_addr;
    mem_word_t mem_wr_data;
    logic start_valid;
    logic start_ready;
    chk_norm_mode_t mode;
    mem_addr_t mem_base_addr;
    logic [5:0] randomness;
    logic result_valid;
    logic result_invalid;

    int checks;
    int value_errors;
    int other_errors;
    logic [31:0] lfsr_state;
    // Flag expected to stay put between a result and the next start
    logic hold_known;
    logic held_flag;

    norm_check_top #(
        .mldsa_n(mldsa_n)
    ) norm_check_top_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .mem_wr_en(mem_wr_en),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .start_valid(start_valid),
        .start_ready(start_ready),
        .mode(mode),
        .mem_base_addr(mem_base_addr),
        .randomness(randomness),
        .result_valid(result_valid),
        .result_invalid(result_invalid)
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, new bit shifted in at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit of the six-bit rotation seed
    task automatic draw_randomness(output logic [5:0] r);
        r = '0;
        for (int i = 0; i < 6; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[4:0], lfsr_state[0]};
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_int(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // Advance to the next falling edge, where outputs are stable and inputs change
    task automatic next_cycle();
        @(negedge clk);
        if (hold_known) begin
            check_bit(result_invalid, held_flag, "held result_invalid");
        end
    endtask

    // Background in every lane of every word, then one lane overwritten
    task automatic load_vector(input int base, input int bg, input int bad_word,
                               input int bad_lane, input int bad_value);
        mem_word_t fill;
        mem_word_t bad;
        logic [reg_size-1:0] bg_slot;
        logic [reg_size-1:0] bad_slot;
        bg_slot = bg[reg_size-1:0];
        bad_slot = bad_value[reg_size-1:0];
        for (int l = 0; l < lanes; l++) begin
            fill[l*reg_size +: reg_size] = bg_slot;
        end
        bad = fill;
        bad[bad_lane*reg_size +: reg_size] = bad_slot;
        for (int j = 0; j < load_words; j++) begin
            next_cycle();
            mem_wr_en = 1'b1;
            mem_wr_addr = mem_addr_t'(base + j);
            mem_wr_data = fill;
        end
        if (bad_word >= 0) begin
            next_cycle();
            mem_wr_addr = mem_addr_t'(base + bad_word);
            mem_wr_data = bad;
        end
        next_cycle();
        mem_wr_en = 1'b0;
    endtask

    // Raises start_valid and returns in the first cycle after the acceptance edge
    task automatic start_run(input chk_norm_mode_t m, input int base, output logic accepted);
        int t;
        logic [5:0] r;
        draw_randomness(r);
        next_cycle();
        mode = m;
        mem_base_addr = mem_addr_t'(base);
        randomness = r;
        start_valid = 1'b1;
        t = 0;
        while (!start_ready && t < ready_limit) begin
            next_cycle();
            t++;
        end
        if (!start_ready) begin
            $display("Timeout at %0t ns: start_ready stayed low, start not accepted", $time);
            other_errors++;
            start_valid = 1'b0;
            accepted = 1'b0;
        end else begin
            @(posedge clk);
            hold_known = 1'b0;
            @(negedge clk);
            start_valid = 1'b0;
            accepted = 1'b1;
        end
    endtask

    // Counts cycles from the first cycle after acceptance up to the result pulse
    task automatic await_result(input int run_words, input logic expected);
        int cycles;
        cycles = 0;
        while (!result_valid && cycles < run_words + wait_margin) begin
            check_bit(start_ready, 1'b0, "start_ready during run");
            @(negedge clk);
            cycles++;
        end
        if (!result_valid) begin
            $display("Timeout at %0t ns: no result_valid within %0d cycles of the start",
                     $time, run_words + wait_margin);
            other_errors++;
        end else begin
            check_int(cycles, run_words + 2, "cycles from start to result_valid");
            check_bit(start_ready, 1'b0, "start_ready with result_valid");
            check_bit(result_invalid, expected, "result_invalid");
            @(negedge clk);
            check_bit(result_valid, 1'b0, "result_valid one cycle after pulse");
            check_bit(start_ready, 1'b1, "start_ready one cycle after result");
            check_bit(result_invalid, expected, "result_invalid after pulse");
            held_flag = expected;
            hold_known = 1'b1;
        end
    endtask

    // Pulses zeroize ten cycles after acceptance and watches that no result follows
    task automatic abort_run(input int run_words);
        for (int i = 0; i < 10; i++) begin
            check_bit(result_valid, 1'b0, "result_valid before zeroize");
            @(negedge clk);
        end
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        check_bit(start_ready, 1'b1, "start_ready after zeroize");
        for (int i = 0; i < run_words + wait_margin; i++) begin
            check_bit(result_valid, 1'b0, "result_valid after zeroize");
            @(negedge clk);
        end
    endtask

    initial begin
        int fd;
        int fields;
        int case_count;
        int f_mode;
        int f_base;
        int f_bg;
        int f_word;
        int f_lane;
        int f_value;
        int f_zero;
        int f_exp;
        int run_words;
        logic accepted;
        logic [8*256-1:0] line;

        clk = 1'b0;
        reset_n = 1'b0;
        zeroize = 1'b0;
        mem_wr_en = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        start_valid = 1'b0;
        mode = chk_z;
        mem_base_addr = '0;
        randomness = '0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        case_count = 0;
        lfsr_state = 32'hfe8a;
        hold_known = 1'b0;
        held_flag = 1'b0;

        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_bit(start_ready, 1'b1, "start_ready after reset");
        check_bit(result_valid, 1'b0, "result_valid after reset");
        check_bit(result_invalid, 1'b0, "result_invalid after reset");

        fd = $fopen("test/norm_check_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/norm_check_stim.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                fields = $fgets(line, fd);
                fields = $sscanf(line, "%d %d %d %d %d %d %d %d", f_mode, f_base, f_bg,
                                 f_word, f_lane, f_value, f_zero, f_exp);
                // Comment and blank lines do not give eight numbers
                if (fields == 8) begin
                    case_count++;
                    if (f_mode == 0) begin
                        run_words = words_per_poly * poly_count_l;
                    end else begin
                        run_words = words_per_poly * poly_count_k;
                    end
                    load_vector(f_base, f_bg, f_word, f_lane, f_value);
                    start_run(chk_norm_mode_t'(f_mode), f_base, accepted);
                    if (accepted && f_zero != 0) begin
                        abort_run(run_words);
                    end else if (accepted) begin
                        await_result(run_words, f_exp[0]);
                    end
                end
            end
            $fclose(fd);
        end
        if (case_count == 0) begin
            $display("No test case was read from the stimulus file");
            other_errors++;
        end

        $display("Cases: %0d, checks: %0d, value errors: %0d, other errors: %0d",
                 case_count, checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/norm_check_pkg.sv
hdl/coeff_mem.sv
hdl/norm_check_unit.sv
hdl/norm_check_ctrl.sv
hdl/norm_check_accum.sv
hdl/norm_check_top.sv
test/norm_check_tb.sv

//--- Makefile
# Verilator build and run of the norm-check testbench

VERILATOR ?= verilator
TOP       ?= norm_check_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ** PASS **
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard hdl/*.sv) $(wildcard test/*.sv)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF -x '$(PASS_TEXT)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/norm_check_stim.txt
# Columns: mode (0 z, 1 r0, 2 ct0), base word address, background coefficient,
# bad word (-1 none), bad lane, bad value, zeroize (1 aborts the run), expected invalid flag
# All-zero vectors in each mode
0 0 0 -1 0 0 0 0
1 32 0 -1 0 0 0 0
2 64 0 -1 0 0 0 0
# Bound edges on the positive side, bound minus one passes and the bound fails
0 96 17 5 0 524167 0 0
0 96 17 5 1 524168 0 1
1 128 8380400 12 2 261767 0 0
1 128 8380400 12 3 261768 0 1
2 160 4096 0 3 261887 0 0
2 160 4096 27 0 261888 0 1
# Negative side, q minus bound fails and q minus bound plus one passes
0 200 0 9 2 7856249 0 1
0 200 0 9 3 7856250 0 0
1 300 1 20 0 8118649 0 1
1 300 1 20 1 8118650 0 0
2 400 8380416 31 1 8118529 0 1
2 400 8380416 31 2 8118530 0 0
# Bad value in polynomial 7, outside the z vector
0 500 3 29 2 4000000 0 0
1 500 3 29 2 4000000 0 1
2 500 3 30 1 4000000 0 1
# Sticky flag, an invalid run then a clean one
1 600 0 0 0 8000000 0 1
1 600 0 -1 0 0 0 0
# Zeroize in mid-run, then the same vector runs to completion
2 700 0 3 0 300000 1 0
2 700 0 3 0 300000 0 1
# Top of the address space
0 992 100 27 3 524168 0 1
0 992 100 27 3 0 0 0
